// File: design/align_ctrl_sync.sv
`timescale 1ns/1ns
`include "bclk_align_defines.svh"

module align_ctrl_sync (
   input  logic SCLK,
   input  logic RESETN,
   input  logic restart,
   output logic restart_clr,
   output logic trng_enable
);

   logic [2:0]                  restart_sync;
   logic [3:0]                  restart_str;
   logic                        restart_edge;
   logic [`ALIGN_RST_DLY_W-1:0] pwr_cnt;

   // Rising edge seen past the first two flops
   assign restart_edge = restart_sync[1] & ~restart_sync[2];
   assign restart_clr  = |restart_str;

   always_ff @(posedge SCLK or negedge RESETN) begin
      if (!RESETN) begin
         restart_sync <= '0;
         restart_str  <= '0;
      end else begin
         restart_sync <= {restart_sync[1:0], restart};
         restart_str  <= {restart_str[2:0], restart_edge};
      end
   end

   // --------------------
   // Power-up delay, stops counting once saturated
   always_ff @(posedge SCLK or negedge RESETN) begin
      if (!RESETN) begin
         pwr_cnt     <= '0;
         trng_enable <= 1'b0;
      end else if (!trng_enable) begin
         if (&pwr_cnt)
            trng_enable <= 1'b1;
         else
            pwr_cnt <= pwr_cnt + 1'b1;
      end
   end

   a_restart_len: assert property (@(posedge SCLK) disable iff (!RESETN)
      $rose(restart_clr) |-> ##4 !restart_clr);

endmodule

// File: design/bclk_align_pkg.sv
`include "bclk_align_defines.svh"

package bclk_align_pkg;

   typedef logic [`ALIGN_TAP_W-1:0]   tap_t;
   typedef logic [`ALIGN_RETRY_W-1:0] retry_cnt_t;

   // Commands towards the delay element
   typedef struct packed {
      logic reset_lane;
      logic clr_flgs;
      logic load;
      logic dir;
      logic move;
   } iod_cmd_t;

   // Status back from the delay element
   typedef struct packed {
      logic early;
      logic late;
      logic oor;
   } iod_flags_t;

   typedef enum logic [3:0] {
      S_IDLE, S_RST_LANE, S_RST_WAIT, S_CLR, S_WAIT, S_STORE, S_MOVE,
      S_SEARCH, S_CTR_LOAD, S_CTR_CMP, S_CTR_MOVE, S_CTR_WAIT, S_DONE, S_ERR
   } align_state_e;

   typedef enum logic [1:0] {
      SR_IDLE, SR_SCAN, SR_CALC
   } search_state_e;

endpackage

// File: design/bclk_align_top.sv
`timescale 1ns/1ns

module bclk_align_top
   import bclk_align_pkg::*;
(
   input  logic       SCLK,
   input  logic       RESETN,
   input  logic       train,
   input  logic       restart,
   input  iod_flags_t iod_flags,
   output iod_cmd_t   iod_cmd,
   output tap_t       tap_dly,
   output logic       align_start,
   output logic       align_done,
   output logic       align_err
);

   logic restart_clr;
   logic trng_enable;
   logic store_wr;
   tap_t store_idx;
   tap_t rd_idx;
   logic rd_noisy;
   logic search_go;
   logic search_done;
   tap_t search_tap;
   logic search_empty;

   align_ctrl_sync u_sync (
      .SCLK        (SCLK),
      .RESETN      (RESETN),
      .restart     (restart),
      .restart_clr (restart_clr),
      .trng_enable (trng_enable)
   );

   flag_sweep_store u_store (
      .SCLK        (SCLK),
      .RESETN      (RESETN),
      .restart_clr (restart_clr),
      .store_wr    (store_wr),
      .store_idx   (store_idx),
      .iod_flags   (iod_flags),
      .rd_idx      (rd_idx),
      .rd_noisy    (rd_noisy)
   );

   eye_window_search u_search (
      .SCLK         (SCLK),
      .RESETN       (RESETN),
      .restart_clr  (restart_clr),
      .search_go    (search_go),
      .rd_noisy     (rd_noisy),
      .rd_idx       (rd_idx),
      .search_done  (search_done),
      .search_tap   (search_tap),
      .search_empty (search_empty)
   );

   clk_align_fsm u_fsm (
      .SCLK         (SCLK),
      .RESETN       (RESETN),
      .restart_clr  (restart_clr),
      .trng_enable  (trng_enable),
      .train        (train),
      .iod_flags    (iod_flags),
      .search_done  (search_done),
      .search_tap   (search_tap),
      .search_empty (search_empty),
      .iod_cmd      (iod_cmd),
      .store_wr     (store_wr),
      .store_idx    (store_idx),
      .search_go    (search_go),
      .tap_dly      (tap_dly),
      .align_start  (align_start),
      .align_done   (align_done),
      .align_err    (align_err)
   );

endmodule

// File: design/clk_align_fsm.sv
`timescale 1ns/1ns
`include "bclk_align_defines.svh"

module clk_align_fsm
   import bclk_align_pkg::*;
(
   input  logic       SCLK,
   input  logic       RESETN,
   input  logic       restart_clr,
   input  logic       trng_enable,
   input  logic       train,
   input  iod_flags_t iod_flags,
   input  logic       search_done,
   input  tap_t       search_tap,
   input  logic       search_empty,
   output iod_cmd_t   iod_cmd,
   output logic       store_wr,
   output tap_t       store_idx,
   output logic       search_go,
   output tap_t       tap_dly,
   output logic       align_start,
   output logic       align_done,
   output logic       align_err
);

   // Idle command word, always incrementing
   localparam iod_cmd_t CMD_IDLE = '{reset_lane: 1'b0, clr_flgs: 1'b0, load: 1'b0,
                                     dir: 1'b1, move: 1'b0};

   align_state_e               state;
   logic [`ALIGN_WAIT_W-1:0]   wait_cnt;
   logic [`ALIGN_STROBE_W-1:0] strb_cnt;
   logic                       strb_wrap;
   retry_cnt_t                 fail_cnt;

   assign strb_wrap = &strb_cnt;
   assign store_wr  = (state == S_STORE);

   always_ff @(posedge SCLK or negedge RESETN) begin
      if (!RESETN) begin
         state       <= S_IDLE;
         iod_cmd     <= CMD_IDLE;
         store_idx   <= '0;
         search_go   <= 1'b0;
         tap_dly     <= '0;
         fail_cnt    <= '0;
         align_start <= 1'b0;
         align_done  <= 1'b0;
         align_err   <= 1'b0;
      end else if (restart_clr) begin
         state       <= S_IDLE;
         iod_cmd     <= CMD_IDLE;
         store_idx   <= '0;
         search_go   <= 1'b0;
         tap_dly     <= '0;
         fail_cnt    <= '0;
         align_start <= 1'b0;
         align_done  <= 1'b0;
         align_err   <= 1'b0;
      end else begin
         search_go <= 1'b0;
         case (state)
            S_IDLE: begin
               if (train && trng_enable) begin
                  iod_cmd.reset_lane <= 1'b1;
                  align_start        <= 1'b1;
                  fail_cnt           <= '0;
                  state              <= S_RST_LANE;
               end
            end
            S_RST_LANE: begin
               if (strb_wrap) begin
                  iod_cmd.reset_lane <= 1'b0;
                  state              <= S_RST_WAIT;
               end
            end
            S_RST_WAIT: begin
               if (wait_cnt == '0) begin
                  iod_cmd.load     <= 1'b1;
                  iod_cmd.clr_flgs <= 1'b1;
                  store_idx        <= '0;
                  state            <= S_CLR;
               end
            end
            // --------------------
            // Sweep, one tap per pass
            S_CLR: begin
               // Also ends the load strobe at sweep start
               if (strb_wrap) begin
                  iod_cmd.load     <= 1'b0;
                  iod_cmd.clr_flgs <= 1'b0;
                  state            <= S_WAIT;
               end
            end
            S_WAIT: begin
               if (wait_cnt == '0) begin
                  if (iod_flags.oor) begin
                     search_go <= 1'b1;
                     state     <= S_SEARCH;
                  end else begin
                     state <= S_STORE;
                  end
               end
            end
            S_STORE: begin
               iod_cmd.move <= 1'b1;
               state        <= S_MOVE;
            end
            S_MOVE: begin
               if (strb_wrap) begin
                  iod_cmd.move     <= 1'b0;
                  iod_cmd.clr_flgs <= 1'b1;
                  store_idx        <= store_idx + 1'b1;
                  state            <= S_CLR;
               end
            end
            S_SEARCH: begin
               if (search_done) begin
                  if (!search_empty) begin
                     tap_dly          <= search_tap;
                     iod_cmd.load     <= 1'b1;
                     iod_cmd.clr_flgs <= 1'b1;
                     store_idx        <= '0;
                     state            <= S_CTR_LOAD;
                  end else if (fail_cnt == retry_cnt_t'(`ALIGN_RETRY_MAX - 1)) begin
                     fail_cnt    <= fail_cnt + 1'b1;
                     align_start <= 1'b0;
                     align_done  <= 1'b1;
                     align_err   <= 1'b1;
                     state       <= S_ERR;
                  end else begin
                     // No eye edge found, sweep again
                     fail_cnt <= fail_cnt + 1'b1;
                     state    <= S_RST_WAIT;
                  end
               end
            end
            // --------------------
            // Reload and walk to the centre tap
            S_CTR_LOAD: begin
               if (strb_wrap) begin
                  iod_cmd.load     <= 1'b0;
                  iod_cmd.clr_flgs <= 1'b0;
                  state            <= S_CTR_CMP;
               end
            end
            S_CTR_CMP: begin
               if (store_idx == tap_dly) begin
                  state <= S_CTR_WAIT;
               end else begin
                  iod_cmd.move <= 1'b1;
                  state        <= S_CTR_MOVE;
               end
            end
            S_CTR_MOVE: begin
               if (strb_wrap) begin
                  iod_cmd.move <= 1'b0;
                  store_idx    <= store_idx + 1'b1;
                  state        <= S_CTR_CMP;
               end
            end
            S_CTR_WAIT: begin
               if (wait_cnt == '0) begin
                  align_start <= 1'b0;
                  align_done  <= 1'b1;
                  state       <= S_DONE;
               end
            end
            // Done follows train
            S_DONE: begin
               if (!train) begin
                  align_done <= 1'b0;
                  state      <= S_IDLE;
               end
            end
            S_ERR: state <= S_ERR;
            default: state <= S_IDLE;
         endcase
      end
   end

   // Settling wait, reloaded ahead of each waiting state
   always_ff @(posedge SCLK or negedge RESETN) begin
      if (!RESETN) begin
         wait_cnt <= '1;
      end else if (restart_clr) begin
         wait_cnt <= '1;
      end else begin
         case (state)
            S_RST_LANE, S_CLR, S_SEARCH, S_CTR_CMP: wait_cnt <= '1;
            S_RST_WAIT, S_WAIT, S_CTR_WAIT:         wait_cnt <= wait_cnt - 1'b1;
            default:                                wait_cnt <= wait_cnt;
         endcase
      end
   end

   // Strobe length counter, free running
   always_ff @(posedge SCLK or negedge RESETN) begin
      if (!RESETN)
         strb_cnt <= '0;
      else
         strb_cnt <= strb_cnt + 1'b1;
   end

   a_load_move_excl: assert property (@(posedge SCLK) disable iff (!RESETN)
      !(iod_cmd.load && iod_cmd.move));

endmodule

// File: design/eye_window_search.sv
`timescale 1ns/1ns
`include "bclk_align_defines.svh"

module eye_window_search
   import bclk_align_pkg::*;
(
   input  logic SCLK,
   input  logic RESETN,
   input  logic restart_clr,
   input  logic search_go,
   input  logic rd_noisy,
   output tap_t rd_idx,
   output logic search_done,
   output tap_t search_tap,
   output logic search_empty
);

   search_state_e         state;
   tap_t                  chk_idx;
   tap_t                  first_idx;
   tap_t                  last_idx;
   logic                  found;
   logic                  last_tap;
   logic [`ALIGN_TAP_W:0] mid_sum;

   // chk_idx is the tap whose flag sits on rd_noisy this cycle
   assign last_tap = (chk_idx == tap_t'(`ALIGN_TAP_CNT - 1));
   assign mid_sum  = {1'b0, first_idx} + {1'b0, last_idx};

   // --------------------
   // Scan control
   always_ff @(posedge SCLK or negedge RESETN) begin
      if (!RESETN) begin
         state        <= SR_IDLE;
         rd_idx       <= '0;
         chk_idx      <= '0;
         found        <= 1'b0;
         search_done  <= 1'b0;
         search_empty <= 1'b0;
      end else if (restart_clr) begin
         state        <= SR_IDLE;
         rd_idx       <= '0;
         chk_idx      <= '0;
         found        <= 1'b0;
         search_done  <= 1'b0;
         search_empty <= 1'b0;
      end else begin
         search_done <= 1'b0;
         case (state)
            SR_IDLE: begin
               // rd_idx already parked at tap 0
               chk_idx <= '0;
               if (search_go) begin
                  rd_idx <= tap_t'(1);
                  found  <= 1'b0;
                  state  <= SR_SCAN;
               end
            end
            SR_SCAN: begin
               rd_idx  <= rd_idx + 1'b1;
               chk_idx <= rd_idx;
               if (rd_noisy)
                  found <= 1'b1;
               // First quiet tap after the run, or end of line
               if ((found && !rd_noisy) || last_tap)
                  state <= SR_CALC;
            end
            SR_CALC: begin
               search_done  <= 1'b1;
               search_empty <= !found;
               rd_idx       <= '0;
               state        <= SR_IDLE;
            end
            default: state <= SR_IDLE;
         endcase
      end
   end

   // --------------------
   // Run edges and centre tap
   always_ff @(posedge SCLK) begin
      if (state == SR_SCAN && rd_noisy) begin
         if (!found)
            first_idx <= chk_idx;
         last_idx <= chk_idx;
      end
      if (state == SR_CALC)
         search_tap <= found ? mid_sum[`ALIGN_TAP_W:1] : '0;
   end

   a_tap_in_run: assert property (@(posedge SCLK) disable iff (!RESETN)
      (search_done && !search_empty) |->
         (search_tap >= first_idx && search_tap <= last_idx));

endmodule

// File: design/flag_sweep_store.sv
`timescale 1ns/1ns
`include "bclk_align_defines.svh"

module flag_sweep_store
   import bclk_align_pkg::*;
(
   input  logic       SCLK,
   input  logic       RESETN,
   input  logic       restart_clr,
   input  logic       store_wr,
   input  tap_t       store_idx,
   input  iod_flags_t iod_flags,
   input  tap_t       rd_idx,
   output logic       rd_noisy
);

   localparam int HALF = `ALIGN_TAP_CNT / 2;

   logic [HALF-1:0]          early_lo;
   logic [HALF-1:0]          early_hi;
   logic [HALF-1:0]          late_lo;
   logic [HALF-1:0]          late_hi;
   logic [`ALIGN_TAP_W-2:0]  wr_off;
   logic [`ALIGN_TAP_W-2:0]  rd_off;

   // Top index bit selects the half
   assign wr_off = store_idx[`ALIGN_TAP_W-2:0];
   assign rd_off = rd_idx[`ALIGN_TAP_W-2:0];

   always_ff @(posedge SCLK) begin
      if (restart_clr) begin
         early_lo <= '0;
         early_hi <= '0;
         late_lo  <= '0;
         late_hi  <= '0;
      end else if (store_wr) begin
         if (store_idx[`ALIGN_TAP_W-1]) begin
            early_hi[wr_off] <= iod_flags.early;
            late_hi[wr_off]  <= iod_flags.late;
         end else begin
            early_lo[wr_off] <= iod_flags.early;
            late_lo[wr_off]  <= iod_flags.late;
         end
      end
   end

   // Noisy readout, one cycle behind rd_idx
   always_ff @(posedge SCLK or negedge RESETN) begin
      if (!RESETN)
         rd_noisy <= 1'b0;
      else if (restart_clr)
         rd_noisy <= 1'b0;
      else if (rd_idx[`ALIGN_TAP_W-1])
         rd_noisy <= early_hi[rd_off] | late_hi[rd_off];
      else
         rd_noisy <= early_lo[rd_off] | late_lo[rd_off];
   end

   // The sequencer must stop storing once the delay line runs out
   a_no_wr_oor: assert property (@(posedge SCLK) disable iff (!RESETN)
      store_wr |-> !iod_flags.oor);

endmodule

// File: include/bclk_align_defines.svh
`ifndef BCLK_ALIGN_DEFINES_SVH
`define BCLK_ALIGN_DEFINES_SVH

// Delay line geometry
`define ALIGN_TAP_CNT   128
`define ALIGN_TAP_W     7

// Settling wait after each flag clear, 8 cycles
`define ALIGN_WAIT_W    3

// Failed sweeps before training gives up
`define ALIGN_RETRY_W   3
`define ALIGN_RETRY_MAX ((1 << `ALIGN_RETRY_W) - 1)

// Power-up settling, 1024 cycles
`define ALIGN_RST_DLY_W 10

// Free-running counter that sets the command strobe length
`define ALIGN_STROBE_W  2

`endif

// File: src.f
+incdir+include
design/bclk_align_pkg.sv
design/align_ctrl_sync.sv
design/flag_sweep_store.sv
design/eye_window_search.sv
design/clk_align_fsm.sv
design/bclk_align_top.sv
tb/iod_lane_model.sv
tb/tb_bclk_align.sv

// File: tb/iod_lane_model.sv
`timescale 1ns/1ns
`include "bclk_align_defines.svh"

module iod_lane_model
   import bclk_align_pkg::*;
(
   input  logic                  SCLK,
   input  logic                  RESETN,
   input  iod_cmd_t              iod_cmd,
   input  logic                  win_en,
   input  tap_t                  win_lo,
   input  tap_t                  win_hi,
   output iod_flags_t            iod_flags,
   output logic [`ALIGN_TAP_W:0] pos
);

   logic move_q;
   logic early_q;
   logic late_q;
   logic in_win;
   logic oor;

   assign in_win    = win_en && (pos >= win_lo) && (pos <= win_hi);
   assign oor       = (pos >= `ALIGN_TAP_CNT);
   assign iod_flags = '{early: early_q, late: late_q, oor: oor};

   // --------------------
   // Tap position, one step per move strobe
   always_ff @(posedge SCLK or negedge RESETN) begin
      if (!RESETN) begin
         pos    <= '0;
         move_q <= 1'b0;
      end else begin
         move_q <= iod_cmd.move;
         if (iod_cmd.reset_lane || iod_cmd.load)
            pos <= '0;
         else if (iod_cmd.move && !move_q && !oor)
            pos <= pos + 1'b1;
      end
   end

   // Sticky flags, even taps look early and odd taps late
   always_ff @(posedge SCLK or negedge RESETN) begin
      if (!RESETN) begin
         early_q <= 1'b0;
         late_q  <= 1'b0;
      end else if (iod_cmd.clr_flgs) begin
         early_q <= 1'b0;
         late_q  <= 1'b0;
      end else if (in_win) begin
         early_q <= early_q | ~pos[0];
         late_q  <= late_q | pos[0];
      end
   end

endmodule

// File: tb/tb_bclk_align.sv
`timescale 1ns/1ns
`include "bclk_align_defines.svh"

module tb_bclk_align
   import bclk_align_pkg::*;
();

   localparam int CYCLE_LIMIT = 80000;

   logic                  SCLK;
   logic                  RESETN;
   logic                  train;
   logic                  restart;
   iod_flags_t            iod_flags;
   iod_cmd_t              iod_cmd;
   tap_t                  tap_dly;
   logic                  align_start;
   logic                  align_done;
   logic                  align_err;
   logic                  win_en;
   tap_t                  win_lo;
   tap_t                  win_hi;
   tap_t                  exp_tap;
   logic [`ALIGN_TAP_W:0] model_pos;
   logic                  load_q = 1'b0;
   int                    load_cnt = 0;
   int                    cycle_cnt = 0;
   int                    err_cnt = 0;
   int                    tests_run = 0;
   int                    tests_failed = 0;
   int                    test_err_base = 0;
   string                 test_name;
   integer                seed = 53813;

   bclk_align_top dut0 (
      .SCLK        (SCLK),
      .RESETN      (RESETN),
      .train       (train),
      .restart     (restart),
      .iod_flags   (iod_flags),
      .iod_cmd     (iod_cmd),
      .tap_dly     (tap_dly),
      .align_start (align_start),
      .align_done  (align_done),
      .align_err   (align_err)
   );

   iod_lane_model u_lane (
      .SCLK      (SCLK),
      .RESETN    (RESETN),
      .iod_cmd   (iod_cmd),
      .win_en    (win_en),
      .win_lo    (win_lo),
      .win_hi    (win_hi),
      .iod_flags (iod_flags),
      .pos       (model_pos)
   );

   initial SCLK = 1'b0;
   always #20 SCLK = ~SCLK;

   // Watchdog covering about eight full sweeps plus margin
   always @(posedge SCLK) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // One load strobe per sweep
   always @(posedge SCLK) begin
      load_q <= iod_cmd.load;
      if (iod_cmd.load && !load_q)
         load_cnt <= load_cnt + 1;
   end

   task automatic report_fail(input string msg);
      $display("FAIL %0t: %s", $time, msg);
      err_cnt++;
   endtask

   // --------------------
   // Protocol checks
   a_done_tap: assert property (@(posedge SCLK) disable iff (!RESETN)
      ($rose(align_done) && !align_err) |-> (tap_dly == exp_tap && model_pos == tap_dly))
      else report_fail($sformatf("done with tap_dly %0d, model at %0d, expected %0d",
                                 tap_dly, model_pos, exp_tap));

   a_err_done: assert property (@(posedge SCLK) disable iff (!RESETN)
      align_err |-> align_done)
      else report_fail("align_err high without align_done");

   a_start_done: assert property (@(posedge SCLK) disable iff (!RESETN)
      !(align_start && align_done))
      else report_fail("align_start and align_done high together");

   task automatic start_test(input string name);
      test_name     = name;
      test_err_base = err_cnt;
      tests_run++;
   endtask

   task automatic end_test();
      if (err_cnt == test_err_base) begin
         $display("Test %0d %s: passed", tests_run, test_name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: failed with %0d bad checks", tests_run, test_name,
                  err_cnt - test_err_base);
      end
   endtask

   task automatic set_window(input logic en, input tap_t lo, input tap_t hi);
      win_en  = en;
      win_lo  = lo;
      win_hi  = hi;
      // Floor of the midpoint of the noisy run
      exp_tap = tap_t'((int'(lo) + int'(hi)) / 2);
   endtask

   task automatic train_to_done();
      train = 1'b1;
      while (!align_done)
         @(negedge SCLK);
   endtask

   task automatic expect_aligned();
      assert (!align_err) else report_fail("align_err set after a good sweep");
      assert (model_pos == exp_tap) else report_fail("model not at the expected tap");
   endtask

   task automatic drop_train();
      train = 1'b0;
      @(negedge SCLK);
      assert (!align_done) else report_fail("align_done still high a cycle after train fell");
   endtask

   task automatic pulse_restart();
      int n;
      n       = 0;
      restart = 1'b1;
      train   = 1'b0;
      while (align_start && n < 8) begin
         @(negedge SCLK);
         n++;
      end
      assert (!align_start) else report_fail("align_start still high 8 cycles after restart");
      repeat (8) @(negedge SCLK);
      restart = 1'b0;
      repeat (4) @(negedge SCLK);
   endtask

   initial begin
      int base;
      RESETN  = 1'b0;
      train   = 1'b0;
      restart = 1'b0;
      set_window(1'b1, tap_t'(40), tap_t'(60));
      repeat (8) @(negedge SCLK);
      RESETN = 1'b1;
      @(negedge SCLK);

      start_test("reset values and power-up delay");
      assert (!align_start && !align_done && !align_err)
         else report_fail("status outputs not low after reset");
      assert (!iod_cmd.reset_lane && !iod_cmd.load && !iod_cmd.move && !iod_cmd.clr_flgs)
         else report_fail("command strobes not low after reset");
      assert (iod_cmd.dir && tap_dly == '0) else report_fail("dir or tap_dly wrong after reset");
      train = 1'b1;
      repeat ((1 << `ALIGN_RST_DLY_W) - 16) begin
         @(negedge SCLK);
         assert (!align_start) else report_fail("training started during power-up delay");
      end
      end_test();

      start_test("window 40..60");
      while (!align_start)
         @(negedge SCLK);
      while (!align_done) begin
         assert (align_start) else report_fail("align_start low during training");
         @(negedge SCLK);
      end
      expect_aligned();
      end_test();

      start_test("edge and random windows");
      drop_train();
      set_window(1'b1, tap_t'(0), tap_t'(9));
      train_to_done();
      expect_aligned();
      drop_train();
      set_window(1'b1, tap_t'(100), tap_t'(100));
      train_to_done();
      expect_aligned();
      drop_train();
      base = {$random(seed)} % 100;
      set_window(1'b1, tap_t'(base), tap_t'(base + {$random(seed)} % 28));
      train_to_done();
      expect_aligned();
      end_test();

      start_test("retrain after train drop");
      drop_train();
      set_window(1'b1, tap_t'(20), tap_t'(31));
      train_to_done();
      expect_aligned();
      end_test();

      start_test("restart during sweep");
      drop_train();
      set_window(1'b1, tap_t'(70), tap_t'(90));
      train = 1'b1;
      while (!align_start)
         @(negedge SCLK);
      while (model_pos < 30)
         @(negedge SCLK);
      pulse_restart();
      // An aborted sweep leaves the delay line where it stopped
      base = model_pos;
      repeat (40) @(negedge SCLK);
      assert (model_pos == base) else report_fail("delay line still stepping after restart");
      train_to_done();
      expect_aligned();
      end_test();

      start_test("no noisy tap gives error");
      drop_train();
      set_window(1'b0, tap_t'(0), tap_t'(0));
      base = load_cnt;
      train_to_done();
      assert (align_err && !align_start) else report_fail("error end without err or with start");
      assert (load_cnt - base == `ALIGN_RETRY_MAX)
         else report_fail($sformatf("%0d sweeps before error", load_cnt - base));
      train = 1'b0;
      repeat (4) @(negedge SCLK);
      assert (align_done && align_err) else report_fail("error status dropped before restart");
      pulse_restart();
      assert (!align_err && !align_done) else report_fail("restart did not clear the error");
      end_test();

      $display("Tests run: %0d, tests failed: %0d, bad checks: %0d",
               tests_run, tests_failed, err_cnt);
      if (err_cnt == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule
